//--- design/dvi_settings.svh
/*
  Widths and per-chip raster geometry for the reduced DVI clock.
  NTSC columns assume 26.59 MHz and PAL assumes 29.56 MHz.
  Horizontal values are in doubled output pixels and vertical values in
  doubled lines. All numbers are fixed, and there is no runtime timing.
*/
`ifndef DVI_SETTINGS_SVH
`define DVI_SETTINGS_SVH

`define DVI_HW 11                       // h counters and line addresses
`define DVI_VW 10                       // v counters
`define DVI_CW 4                        // color index

// ------------------------------------------------------------
// 6569 R1/R3, 945 wide x 624 high, 782x576 visible
// ------------------------------------------------------------
`define PAL_MAX_WIDTH     11'd944
`define PAL_OFFSET        11'd70
`define PAL_HA_END        11'd914       // blank from here
`define PAL_HS_STA        11'd0
`define PAL_HS_END        11'd64        // 64 wide pulse
`define PAL_HA_STA        11'd132
`define PAL_VA_END        10'd592
`define PAL_VS_STA        10'd7
`define PAL_VS_END        10'd12
`define PAL_VA_STA        10'd17        // 576 lines: 17..592
`define PAL_MAX_HEIGHT    10'd623

// ------------------------------------------------------------
// 6567R8, 845 wide x 526 high
// ------------------------------------------------------------
`define NTSCR8_MAX_WIDTH  11'd844
`define NTSCR8_OFFSET     11'd130
`define NTSCR8_HA_END     11'd826
`define NTSCR8_HS_STA     11'd11
`define NTSCR8_HS_END     11'd75
`define NTSCR8_HA_STA     11'd106
`define NTSCR8_VA_END     10'd22        // window wraps past max_height
`define NTSCR8_VS_STA     10'd24
`define NTSCR8_VS_END     10'd46
`define NTSCR8_VA_STA     10'd66
`define NTSCR8_MAX_HEIGHT 10'd525

// 6567R56A, 832 wide x 524 high
`define NTSCR56_MAX_WIDTH  11'd831
`define NTSCR56_OFFSET     11'd142
`define NTSCR56_HA_END     11'd814
`define NTSCR56_HS_STA     11'd2
`define NTSCR56_HS_END     11'd66
`define NTSCR56_HA_STA     11'd90
`define NTSCR56_VA_END     10'd22
`define NTSCR56_VS_STA     10'd24
`define NTSCR56_VS_END     10'd46
`define NTSCR56_VA_STA     10'd66
`define NTSCR56_MAX_HEIGHT 10'd523

`endif

//--- design/dvi_pkg.sv
/*
  Shared types for the DVI sync generator.
  The chip encoding follows the video chip config: bit 0 set means PAL.
*/
`include "dvi_settings.svh"

package dvi_pkg;

    // chip model, bit 0 marks the PAL parts
    typedef enum logic [1:0] {
        chip_6567r56a = 2'd0,
        chip_6569r3   = 2'd1,
        chip_6567r8   = 2'd2,
        chip_6569r1   = 2'd3
    } chip_e;

    typedef logic [`DVI_HW-1:0] hcount_t;   // h position or line address
    typedef logic [`DVI_VW-1:0] vcount_t;   // v position
    typedef logic [`DVI_CW-1:0] color_t;    // palette index

endpackage

//--- design/dvi_timing_table.sv
/*
  Per-chip raster limits and window edges, registered.
  The table follows chip only while rst is low. chip must be set up
  during reset and is held for the rest of the run.
*/
`include "dvi_settings.svh"

module dvi_timing_table import dvi_pkg::*; (
    input  logic    clk_dvi,
    input  logic    rst,
    input  chip_e   chip,
    output hcount_t max_width,
    output hcount_t x_offset,
    output hcount_t hs_sta,
    output hcount_t hs_end,
    output hcount_t ha_sta,
    output hcount_t ha_end,
    output vcount_t max_height,
    output vcount_t vs_sta,
    output vcount_t vs_end,
    output vcount_t va_sta,
    output vcount_t va_end
);

    // loads under reset only, so counters never see a table change
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            case (chip)
                chip_6569r1, chip_6569r3: begin
                    max_width  <= `PAL_MAX_WIDTH;
                    x_offset   <= `PAL_OFFSET;
                    hs_sta     <= `PAL_HS_STA;
                    hs_end     <= `PAL_HS_END;
                    ha_sta     <= `PAL_HA_STA;
                    ha_end     <= `PAL_HA_END;
                    max_height <= `PAL_MAX_HEIGHT;
                    vs_sta     <= `PAL_VS_STA;
                    vs_end     <= `PAL_VS_END;
                    va_sta     <= `PAL_VA_STA;
                    va_end     <= `PAL_VA_END;
                end
                chip_6567r8: begin
                    max_width  <= `NTSCR8_MAX_WIDTH;
                    x_offset   <= `NTSCR8_OFFSET;
                    hs_sta     <= `NTSCR8_HS_STA;
                    hs_end     <= `NTSCR8_HS_END;
                    ha_sta     <= `NTSCR8_HA_STA;
                    ha_end     <= `NTSCR8_HA_END;
                    max_height <= `NTSCR8_MAX_HEIGHT;
                    vs_sta     <= `NTSCR8_VS_STA;
                    vs_end     <= `NTSCR8_VS_END;
                    va_sta     <= `NTSCR8_VA_STA;
                    va_end     <= `NTSCR8_VA_END;
                end
                default: begin                      // 6567R56A
                    max_width  <= `NTSCR56_MAX_WIDTH;
                    x_offset   <= `NTSCR56_OFFSET;
                    hs_sta     <= `NTSCR56_HS_STA;
                    hs_end     <= `NTSCR56_HS_END;
                    ha_sta     <= `NTSCR56_HA_STA;
                    ha_end     <= `NTSCR56_HA_END;
                    max_height <= `NTSCR56_MAX_HEIGHT;
                    vs_sta     <= `NTSCR56_VS_STA;
                    vs_end     <= `NTSCR56_VS_END;
                    va_sta     <= `NTSCR56_VA_STA;
                    va_end     <= `NTSCR56_VA_END;
                end
            endcase
        end
    end

endmodule

//--- design/dvi_raster_counter.sv
/*
  Free-running output raster counters.
  Line period is max_width+1 clocks, frame is max_height+1 lines.
  half_bright flips each line and restarts at 0 on the frame wrap.
*/
module dvi_raster_counter import dvi_pkg::*; (
    input  logic    clk_dvi,
    input  logic    rst,
    input  hcount_t max_width,
    input  vcount_t max_height,
    output hcount_t h_count,
    output vcount_t v_count,
    output logic    half_bright
);

    logic h_wrap;   // last pixel of the line
    logic v_wrap;   // last line of the frame

    assign h_wrap = (h_count >= max_width);
    assign v_wrap = (v_count >= max_height);

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            h_count     <= '0;
            v_count     <= '0;
            half_bright <= 1'b0;
        end else if (!h_wrap) begin
            h_count <= h_count + 1'b1;
        end else begin
            h_count <= '0;
            if (!v_wrap) begin
                v_count     <= v_count + 1'b1;
                half_bright <= ~half_bright;        // dim every other doubled line
            end else begin
                v_count     <= '0;
                half_bright <= 1'b0;                // frame always starts bright
            end
        end
    end

endmodule

//--- design/dvi_sync_gen.sv
/*
  Sync and active-video flags, one clock behind the counters.
  Polarity inputs high mean active-high pulses.
  With enable_csync, hsync carries composite sync and vsync stays 0.
  PAL windows are a plain range. NTSC vertical windows wrap past line 0.
*/
module dvi_sync_gen import dvi_pkg::*; (
    input  logic    clk_dvi,
    input  logic    rst,
    input  chip_e   chip,
    input  logic    hpolarity,
    input  logic    vpolarity,
    input  logic    enable_csync,
    input  hcount_t h_count,
    input  vcount_t v_count,
    input  hcount_t hs_sta,
    input  hcount_t hs_end,
    input  hcount_t ha_sta,
    input  hcount_t ha_end,
    input  vcount_t vs_sta,
    input  vcount_t vs_end,
    input  vcount_t va_sta,
    input  vcount_t va_end,
    output logic    hsync,
    output logic    vsync,
    output logic    active
);

    logic hsync_raw, vsync_raw, csync_raw;
    logic hsync_pol, vsync_pol, csync_pol;
    logic h_active, v_active_pal, v_active_ntsc;

    // ------------------------------------------------------------
    // raw active-high sync
    // ------------------------------------------------------------
    assign hsync_raw = (h_count >= hs_sta) && (h_count < hs_end);

    // starts at (vs_sta, hs_sta), ends before (vs_end, hs_end)
    assign vsync_raw = ((v_count == vs_sta && h_count >= hs_sta) || v_count > vs_sta) &&
                       ((v_count == vs_end && h_count < hs_end) || v_count < vs_end);

    assign csync_raw = hsync_raw | vsync_raw;

    assign hsync_pol = hpolarity ? hsync_raw : ~hsync_raw;
    assign vsync_pol = vpolarity ? vsync_raw : ~vsync_raw;
    assign csync_pol = hpolarity ? csync_raw : ~csync_raw;    // csync follows hpolarity

    // ------------------------------------------------------------
    // active window
    // ------------------------------------------------------------
    assign h_active      = (h_count > ha_sta) && (h_count <= ha_end);
    assign v_active_pal  = (v_count >= va_sta) && (v_count <= va_end);   // inclusive
    assign v_active_ntsc = (v_count >= va_sta) || (v_count < va_end);    // wraps

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            active <= 1'b0;
        end else begin
            hsync  <= enable_csync ? csync_pol : hsync_pol;
            vsync  <= enable_csync ? 1'b0 : vsync_pol;
            active <= h_active && (chip[0] ? v_active_pal : v_active_ntsc);
        end
    end

endmodule

//--- design/dvi_line_ram.sv
/*
  Simple dual-port line memory, 2**addr_width words.
  The read is registered and dout holds while re is low.
  Contents are undefined until written.
*/
module dvi_line_ram #(
    parameter int addr_width = 11,
    parameter int data_width = 4
) (
    input  logic                  clk_dvi,
    input  logic                  we,
    input  logic [addr_width-1:0] wr_addr,
    input  logic [data_width-1:0] din,
    input  logic                  re,
    input  logic [addr_width-1:0] rd_addr,
    output logic [data_width-1:0] dout
);

    logic [data_width-1:0] mem [2**addr_width];   // maps to block RAM

    always_ff @(posedge clk_dvi) begin
        if (we)
            mem[wr_addr] <= din;
    end

    always_ff @(posedge clk_dvi) begin
        if (re)
            dout <= mem[rd_addr];   // one clock read
    end

endmodule

//--- design/dvi_line_buffer.sv
/*
  Two-line double buffer between the native writer and the doubled reader.
  A strobed write at raster_x 0 swaps the buffers, and that write already
  lands in the new write buffer. The reader addresses h_count + x_offset,
  and pixel_out follows 2 clocks later. There is no back-pressure.
*/
module dvi_line_buffer import dvi_pkg::*; (
    input  logic    clk_dvi,
    input  logic    rst,
    input  logic    pix_wr,
    input  hcount_t raster_x,
    input  color_t  pixel_in,
    input  hcount_t h_count,
    input  hcount_t x_offset,
    output color_t  pixel_out
);

    logic    swap;          // 1: write ram0, read ram1
    logic    swap_nxt;
    logic    swap_d;        // matches the ram data now on dout
    hcount_t rd_addr;
    color_t  dout0, dout1;

    // swap on the line-start strobe, same edge as that write
    assign swap_nxt = swap ^ (pix_wr && (raster_x == '0));
    assign rd_addr  = h_count + x_offset;

    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            swap   <= 1'b0;
            swap_d <= 1'b0;
        end else begin
            swap   <= swap_nxt;
            swap_d <= swap;
        end
    end

    // ------------------------------------------------------------
    // the two line memories
    // ------------------------------------------------------------
    dvi_line_ram #(
        .addr_width ($bits(hcount_t)),
        .data_width ($bits(color_t))
    ) u_ram0 (
        .clk_dvi (clk_dvi),
        .we      (pix_wr & swap_nxt),
        .wr_addr (raster_x),
        .din     (pixel_in),
        .re      (~swap),               // read side while ram1 fills
        .rd_addr (rd_addr),
        .dout    (dout0)
    );

    dvi_line_ram #(
        .addr_width ($bits(hcount_t)),
        .data_width ($bits(color_t))
    ) u_ram1 (
        .clk_dvi (clk_dvi),
        .we      (pix_wr & ~swap_nxt),
        .wr_addr (raster_x),
        .din     (pixel_in),
        .re      (swap),
        .rd_addr (rd_addr),
        .dout    (dout1)
    );

    // output register, second clock of latency
    always_ff @(posedge clk_dvi) begin
        if (!rst)
            pixel_out <= '0;
        else
            pixel_out <= swap_d ? dout1 : dout0;
    end

endmodule

//--- design/dvi_sync_top.sv
/*
  DVI raster sync generator with a one-line double buffer, on clk_dvi.
  chip may change only while rst is low.
  hsync, vsync and active lag the raster by 1 clock, pixel_out by 2.
*/
module dvi_sync_top import dvi_pkg::*; (
    input  logic    clk_dvi,
    input  logic    rst,
    input  chip_e   chip,
    input  logic    hpolarity,
    input  logic    vpolarity,
    input  logic    enable_csync,
    input  logic    pix_wr,
    input  hcount_t raster_x,
    input  color_t  pixel_in,
    output logic    hsync,
    output logic    vsync,
    output logic    active,
    output logic    half_bright,
    output color_t  pixel_out
);

    hcount_t max_width, x_offset, hs_sta, hs_end, ha_sta, ha_end;
    vcount_t max_height, vs_sta, vs_end, va_sta, va_end;
    hcount_t h_count;
    vcount_t v_count;

    // ------------------------------------------------------------
    // timing and raster
    // ------------------------------------------------------------
    dvi_timing_table u_table (
        .clk_dvi (clk_dvi), .rst (rst), .chip (chip),
        .max_width (max_width), .x_offset (x_offset),
        .hs_sta (hs_sta), .hs_end (hs_end), .ha_sta (ha_sta), .ha_end (ha_end),
        .max_height (max_height),
        .vs_sta (vs_sta), .vs_end (vs_end), .va_sta (va_sta), .va_end (va_end)
    );

    dvi_raster_counter u_counter (
        .clk_dvi (clk_dvi), .rst (rst),
        .max_width (max_width), .max_height (max_height),
        .h_count (h_count), .v_count (v_count), .half_bright (half_bright)
    );

    dvi_sync_gen u_sync (
        .clk_dvi (clk_dvi), .rst (rst), .chip (chip),
        .hpolarity (hpolarity), .vpolarity (vpolarity), .enable_csync (enable_csync),
        .h_count (h_count), .v_count (v_count),
        .hs_sta (hs_sta), .hs_end (hs_end), .ha_sta (ha_sta), .ha_end (ha_end),
        .vs_sta (vs_sta), .vs_end (vs_end), .va_sta (va_sta), .va_end (va_end),
        .hsync (hsync), .vsync (vsync), .active (active)
    );

    // pixel path
    dvi_line_buffer u_linebuf (
        .clk_dvi (clk_dvi), .rst (rst),
        .pix_wr (pix_wr), .raster_x (raster_x), .pixel_in (pixel_in),
        .h_count (h_count), .x_offset (x_offset),
        .pixel_out (pixel_out)
    );

endmodule

//--- verif/dvi_sync_checker.sv
/*
  Bound property checks on the sync top level ports.
  The raster model restarts at reset release and expects chip and the
  sync selects to stay fixed while rst is high.
  Failing properties are counted in failures for the testbench to see.
*/
`include "dvi_settings.svh"

module dvi_sync_checker import dvi_pkg::*; (
    input logic   clk_dvi,
    input logic   rst,
    input chip_e  chip,
    input logic   hpolarity,
    input logic   vpolarity,
    input logic   enable_csync,
    input logic   hsync,
    input logic   vsync,
    input logic   active,
    input logic   half_bright,
    input color_t pixel_out
);
    timeunit 1ns;
    timeprecision 100ps;

    int   max_w, max_h, hs_sta, hs_end, vs_sta, vs_end;
    int   ch, cv;           // mirror of the dut raster counters
    int   ch_d, cv_d;       // position that the sync outputs describe
    logic live;             // outputs valid after the first clock out of reset
    logic raw_h, raw_v;
    int   failures = 0;

    // geometry from the chip tables
    always_comb begin
        case (chip)
            chip_6569r1, chip_6569r3: begin
                max_w  = `PAL_MAX_WIDTH;
                max_h  = `PAL_MAX_HEIGHT;
                hs_sta = `PAL_HS_STA;
                hs_end = `PAL_HS_END;
                vs_sta = `PAL_VS_STA;
                vs_end = `PAL_VS_END;
            end
            chip_6567r8: begin
                max_w  = `NTSCR8_MAX_WIDTH;
                max_h  = `NTSCR8_MAX_HEIGHT;
                hs_sta = `NTSCR8_HS_STA;
                hs_end = `NTSCR8_HS_END;
                vs_sta = `NTSCR8_VS_STA;
                vs_end = `NTSCR8_VS_END;
            end
            default: begin
                max_w  = `NTSCR56_MAX_WIDTH;
                max_h  = `NTSCR56_MAX_HEIGHT;
                hs_sta = `NTSCR56_HS_STA;
                hs_end = `NTSCR56_HS_END;
                vs_sta = `NTSCR56_VS_STA;
                vs_end = `NTSCR56_VS_END;
            end
        endcase
    end

    // ------------------------------------------------------------
    // reference raster
    // ------------------------------------------------------------
    always_ff @(posedge clk_dvi) begin
        if (!rst) begin
            ch   <= 0;
            cv   <= 0;
            live <= 1'b0;
        end else begin
            ch <= (ch >= max_w) ? 0 : ch + 1;
            if (ch >= max_w)
                cv <= (cv >= max_h) ? 0 : cv + 1;     // frame wrap
            live <= 1'b1;
        end
        ch_d <= ch;                                    // one clock sync latency
        cv_d <= cv;
    end

    assign raw_h = (ch_d >= hs_sta) && (ch_d < hs_end);
    // from (vs_sta, hs_sta) up to but not including (vs_end, hs_end)
    assign raw_v = (cv_d > vs_sta || (cv_d == vs_sta && ch_d >= hs_sta)) &&
                   (cv_d < vs_end || (cv_d == vs_end && ch_d < hs_end));

    // ------------------------------------------------------------
    // properties
    // ------------------------------------------------------------
    a_reset: assert property (@(posedge clk_dvi)
        !rst |=> !hsync && !vsync && !active && !half_bright && pixel_out == '0)
        else begin failures++; $error("outputs not cleared by reset"); end

    a_hsync: assert property (@(posedge clk_dvi) disable iff (!rst)
        live && !enable_csync |-> hsync == (raw_h ? hpolarity : !hpolarity))
        else begin failures++; $error("hsync pulse out of place"); end

    a_vsync: assert property (@(posedge clk_dvi) disable iff (!rst)
        live && !enable_csync |-> vsync == (raw_v ? vpolarity : !vpolarity))
        else begin failures++; $error("vsync pulse out of place"); end

    a_csync_vsync_low: assert property (@(posedge clk_dvi) disable iff (!rst)
        live && enable_csync |-> !vsync)
        else begin failures++; $error("vsync driven in csync mode"); end

    a_csync_on: assert property (@(posedge clk_dvi) disable iff (!rst)
        live && enable_csync && (raw_h || raw_v) |-> hsync == hpolarity)
        else begin failures++; $error("csync missing during sync"); end

endmodule

bind dvi_sync_top dvi_sync_checker i_chk (
    .clk_dvi      (clk_dvi),
    .rst          (rst),
    .chip         (chip),
    .hpolarity    (hpolarity),
    .vpolarity    (vpolarity),
    .enable_csync (enable_csync),
    .hsync        (hsync),
    .vsync        (vsync),
    .active       (active),
    .half_bright  (half_bright),
    .pixel_out    (pixel_out)
);

//--- verif/tb_dvi_sync.sv
/*
  Testbench for the DVI sync top level, runs three chips for two frames each.
  The reference raster restarts at each reset release.
  Sync timing is checked by the bound checker, active window,
  half_bright and line buffer data are checked here.
*/
`include "dvi_settings.svh"

module tb_dvi_sync import dvi_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    logic    clk_dvi, rst, hpolarity, vpolarity, enable_csync, pix_wr;
    chip_e   chip;
    hcount_t raster_x;
    color_t  pixel_in;
    logic    hsync, vsync, active, half_bright;
    color_t  pixel_out;

    logic [31:0] lfsr = 32'hfc325570;
    color_t      line_copy [2048];     // what was written into the buffer
    int   maxw, maxh, xoff, ha_sta, ha_end, va_sta, va_end;
    logic pal;
    int   mh, mv, h1, v1, h2;           // dut counters and their delayed copies
    logic live;
    int   act_cnt, act_lines, frames;
    int   cmp_left = 0;                 // pixels still to compare

    dvi_sync_top i_dut (
        .clk_dvi (clk_dvi), .rst (rst), .chip (chip),
        .hpolarity (hpolarity), .vpolarity (vpolarity), .enable_csync (enable_csync),
        .pix_wr (pix_wr), .raster_x (raster_x), .pixel_in (pixel_in),
        .hsync (hsync), .vsync (vsync), .active (active),
        .half_bright (half_bright), .pixel_out (pixel_out)
    );

    initial begin
        clk_dvi = 1'b0;
        forever #4 clk_dvi = ~clk_dvi;      // 125 MHz bench clock
    end

    // ------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------
    function automatic int rand_bits(input int n);   // one lfsr step per bit
        int v;
        v = 0;
        repeat (n) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v = (v << 1) | lfsr[0];
        end
        return v;
    endfunction

    function automatic int two_frames(input int w, input int h);
        return 2 * (w + 1) * (h + 1);
    endfunction

    function automatic logic line_on(input int v);
        if (pal)
            return (v >= va_sta) && (v <= va_end);
        return (v >= va_sta) || (v < va_end);         // ntsc window wraps
    endfunction

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic mismatch(input string test, input int exp, input int act);
        fail_now($sformatf("MISMATCH %s expected %0d actual %0d", test, exp, act));
    endtask

    task automatic set_geometry(input int w, input int h, input int off, input int has,
                                input int hae, input int vas, input int vae, input logic p);
        maxw   = w;
        maxh   = h;
        xoff   = off;
        ha_sta = has;
        ha_end = hae;
        va_sta = vas;
        va_end = vae;
        pal    = p;
    endtask

    // ------------------------------------------------------------
    // reference raster and checks
    // ------------------------------------------------------------
    always @(posedge clk_dvi) begin
        if (i_dut.i_chk.failures != 0)
            fail_now("a bound sync assertion failed");
        if (!rst) begin
            mh        <= 0;
            mv        <= 0;
            live      <= 1'b0;
            act_cnt   = 0;
            act_lines = 0;
        end else begin
            mh <= (mh == maxw) ? 0 : mh + 1;
            if (mh == maxw)
                mv <= (mv == maxh) ? 0 : mv + 1;
            live <= 1'b1;
            // even line count per frame, so the flag is the line parity
            if (half_bright !== mv[0])
                mismatch("half_bright", mv[0], half_bright);
            if (live) begin
                if (active)
                    act_cnt++;
                if (h1 == maxw) begin                 // end of the line just seen
                    if (act_cnt != (line_on(v1) ? ha_end - ha_sta : 0))
                        mismatch("active_per_line", line_on(v1) ? ha_end - ha_sta : 0, act_cnt);
                    if (act_cnt != 0)
                        act_lines++;
                    act_cnt = 0;
                    if (v1 == maxh) begin
                        if (act_lines != (pal ? va_end - va_sta + 1 : maxh + 1 - va_sta + va_end))
                            mismatch("active_lines", pal ? va_end - va_sta + 1
                                     : maxh + 1 - va_sta + va_end, act_lines);
                        act_lines = 0;
                        frames++;
                    end
                end
            end
            if (cmp_left > 0) begin                   // pixel_out follows h by 2 clocks
                if (pixel_out !== line_copy[h2 + xoff])
                    mismatch("line_buffer", line_copy[h2 + xoff], pixel_out);
                cmp_left <= cmp_left - 1;
            end
        end
        h1 <= mh;
        v1 <= mv;
        h2 <= h1;
    end

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic run_chip(input chip_e c, input logic csync_on);
        int color;
        rst          <= 1'b0;
        chip         <= c;
        hpolarity    <= rand_bits(1) != 0;
        vpolarity    <= rand_bits(1) != 0;
        enable_csync <= csync_on;
        pix_wr       <= 1'b0;
        case (c)
            chip_6569r1, chip_6569r3:
                set_geometry(`PAL_MAX_WIDTH, `PAL_MAX_HEIGHT, `PAL_OFFSET, `PAL_HA_STA,
                             `PAL_HA_END, `PAL_VA_STA, `PAL_VA_END, 1'b1);
            chip_6567r8:
                set_geometry(`NTSCR8_MAX_WIDTH, `NTSCR8_MAX_HEIGHT, `NTSCR8_OFFSET,
                             `NTSCR8_HA_STA, `NTSCR8_HA_END, `NTSCR8_VA_STA,
                             `NTSCR8_VA_END, 1'b0);
            default:
                set_geometry(`NTSCR56_MAX_WIDTH, `NTSCR56_MAX_HEIGHT, `NTSCR56_OFFSET,
                             `NTSCR56_HA_STA, `NTSCR56_HA_END, `NTSCR56_VA_STA,
                             `NTSCR56_VA_END, 1'b0);
        endcase
        frames = 0;
        repeat (10) @(posedge clk_dvi);
        rst <= 1'b1;
        for (int x = 0; x <= maxw + xoff; x++) begin   // one random line
            @(posedge clk_dvi);
            color        = rand_bits(4);
            line_copy[x] = color_t'(color);
            pix_wr       <= 1'b1;
            raster_x     <= hcount_t'(x);
            pixel_in     <= color_t'(color);
        end
        @(posedge clk_dvi);
        raster_x <= '0;                                  // swap, lands in the other ram
        pixel_in <= color_t'(rand_bits(4));
        @(posedge clk_dvi);
        pix_wr <= 1'b0;
        repeat (2) @(posedge clk_dvi);
        cmp_left <= maxw + 1;                            // one full output line
        wait (frames >= 2);
    endtask

    initial begin
        rst          <= 1'b0;
        chip         <= chip_6569r3;
        hpolarity    <= 1'b0;
        vpolarity    <= 1'b0;
        enable_csync <= 1'b0;
        pix_wr       <= 1'b0;
        raster_x     <= '0;
        pixel_in     <= '0;
        run_chip(chip_6569r3, 1'b0);
        run_chip(chip_6567r8, 1'b1);
        run_chip(chip_6567r56a, rand_bits(1) != 0);
        @(negedge clk_dvi);                              // last edge's assertions settle
        if (i_dut.i_chk.failures == 0) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            fail_now("bound sync assertions reported failures");
        end
    end

    initial begin
        real limit;
        limit = 1.2 * 8.0 * (two_frames(`PAL_MAX_WIDTH, `PAL_MAX_HEIGHT)
                + two_frames(`NTSCR8_MAX_WIDTH, `NTSCR8_MAX_HEIGHT)
                + two_frames(`NTSCR56_MAX_WIDTH, `NTSCR56_MAX_HEIGHT) + 30);
        #(limit);
        fail_now("watchdog expired before all chip runs finished");
    end

endmodule

//--- src.f
+incdir+design
design/dvi_pkg.sv
design/dvi_timing_table.sv
design/dvi_raster_counter.sv
design/dvi_sync_gen.sv
design/dvi_line_ram.sv
design/dvi_line_buffer.sv
design/dvi_sync_top.sv
verif/dvi_sync_checker.sv
verif/tb_dvi_sync.sv

//--- run.sh
#!/bin/sh
# build and run the DVI sync testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dvi_sync -f src.f -o sim_dvi_sync

# the testbench stops itself on failure, so keep its output for the search
out=$(./obj_dir/sim_dvi_sync +verilator+error+limit+100 2>&1) || true
echo "$out"

echo "$out" | grep -q "SIMULATION PASSED"
